// File: Makefile
TOP := tb_int_exec

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f int_exec.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/alu.sv
`timescale 1ns/10ps

module alu import int_exec_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_wb_stall,

    fu_issue_if.exec  in,

    // early bypass
    output logic      o_willwrite_vld,
    output preg_idx_t o_willwrite_idx,
    output xdata_t    o_willwrite_data,

    // writeback
    output logic      o_wb_vld,
    output wb_info_t  o_wb_info
);

    // execute stage
    logic             exe_vld;
    micop_t           exe_micop;
    xdata_t           exe_src0;
    xdata_t           exe_src1;
    logic [IMM_W-1:0] exe_imm;
    logic             exe_rd_wen;
    preg_idx_t        exe_rd_idx;
    rob_idx_t         exe_rob_idx;

    logic [5:0]  shamt;
    logic [4:0]  shamt_w;
    xdata_t      res_add;
    xdata_t      res_sub;
    logic [31:0] sllw_lo;
    logic [31:0] srlw_lo;
    logic [31:0] sraw_lo;
    xdata_t      calc_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_vld    <= 1'b0;
            exe_rd_wen <= 1'b0;
        end else if (!i_wb_stall) begin
            exe_vld     <= in.vld;
            exe_micop   <= in.micop;
            exe_src0    <= in.src0;
            exe_src1    <= in.src1;
            exe_imm     <= in.imm;
            exe_rd_wen  <= in.rd_wen;
            exe_rd_idx  <= in.rd_idx;
            exe_rob_idx <= in.rob_idx;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    assign shamt   = exe_src1[5:0];
    assign shamt_w = exe_src1[4:0];   // W forms

    assign res_add = exe_src0 + exe_src1;
    assign res_sub = exe_src0 - exe_src1;
    assign sllw_lo = exe_src0[31:0] << shamt_w;
    assign srlw_lo = exe_src0[31:0] >> shamt_w;
    assign sraw_lo = $signed(exe_src0[31:0]) >>> shamt_w;

    always_comb begin
        case (exe_micop)
            lui:     calc_data = {{(XLEN-32){exe_imm[IMM_W-1]}}, exe_imm, 12'b0};
            add:     calc_data = res_add;
            sub:     calc_data = res_sub;
            addw:    calc_data = {{(XLEN-32){res_add[31]}}, res_add[31:0]};
            subw:    calc_data = {{(XLEN-32){res_sub[31]}}, res_sub[31:0]};
            sll:     calc_data = exe_src0 << shamt;
            srl:     calc_data = exe_src0 >> shamt;
            sra:     calc_data = $signed(exe_src0) >>> shamt;
            sllw:    calc_data = {{(XLEN-32){sllw_lo[31]}}, sllw_lo};
            srlw:    calc_data = {{(XLEN-32){srlw_lo[31]}}, srlw_lo};
            sraw:    calc_data = {{(XLEN-32){sraw_lo[31]}}, sraw_lo};
            op_xor:  calc_data = exe_src0 ^ exe_src1;
            op_or:   calc_data = exe_src0 | exe_src1;
            op_and:  calc_data = exe_src0 & exe_src1;
            slt:     calc_data = {{(XLEN-1){1'b0}}, $signed(exe_src0) < $signed(exe_src1)};
            sltu:    calc_data = {{(XLEN-1){1'b0}}, exe_src0 < exe_src1};
            default: calc_data = '0;
        endcase
    end

    assign o_willwrite_vld  = exe_vld && exe_rd_wen;
    assign o_willwrite_idx  = exe_rd_idx;
    assign o_willwrite_data = calc_data;

    ////////////////////////////////////////////////////////////////////////////
    // writeback register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            o_wb_vld         <= 1'b0;
            o_wb_info.rd_wen <= 1'b0;
        end else if (!i_wb_stall) begin
            o_wb_vld          <= exe_vld;
            o_wb_info.rob_idx <= exe_rob_idx;
            o_wb_info.rd_wen  <= exe_vld && exe_rd_wen;
            o_wb_info.rd_idx  <= exe_rd_idx;
            o_wb_info.result  <= calc_data;
        end
    end

    // issuer must never hand us an undefined encoding
    a_legal_micop: assert property (
        @(posedge clk) disable iff (rst)
        exe_vld |-> ($unsigned(exe_micop) < NUM_MICOPS)
    ) else $error("illegal micro-op in execute stage");

    // record held until the consumer takes it
    a_wb_hold: assert property (
        @(posedge clk) disable iff (rst)
        (o_wb_vld && i_wb_stall) |=> (o_wb_vld && $stable(o_wb_info))
    ) else $error("writeback record changed under stall");

endmodule

// File: hw/fu_issue_if.sv
`timescale 1ns/10ps

// one micro-op with its operands already read out
interface fu_issue_if import int_exec_pkg::*; ();

    logic             vld;
    micop_t           micop;
    xdata_t           src0;
    xdata_t           src1;     // rs2 or sign-extended imm
    logic [IMM_W-1:0] imm;      // raw, lui only
    logic             rd_wen;
    preg_idx_t        rd_idx;
    rob_idx_t         rob_idx;

    modport read_out (
        output vld, micop, src0, src1, imm, rd_wen, rd_idx, rob_idx
    );

    modport exec (
        input vld, micop, src0, src1, imm, rd_wen, rd_idx, rob_idx
    );

endinterface

// File: hw/int_exec_pkg.sv
package int_exec_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 64;
    localparam int NUM_PREGS  = 32;
    localparam int PREG_W     = 5;     // log2 of NUM_PREGS
    localparam int ROB_W      = 6;
    localparam int IMM_W      = 20;
    localparam int MICOP_W    = 5;
    localparam int NUM_MICOPS = 16;    // legal encodings are 0 .. NUM_MICOPS-1

    ////////////////////////////////////////////////////////////////////////////
    // basic types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [PREG_W-1:0] preg_idx_t;
    typedef logic [ROB_W-1:0]  rob_idx_t;
    typedef logic [XLEN-1:0]   xdata_t;

    // integer micro-ops, RV64I subset
    typedef enum logic [MICOP_W-1:0] {
        lui    = 5'd0,
        add    = 5'd1,
        sub    = 5'd2,
        addw   = 5'd3,
        subw   = 5'd4,
        sll    = 5'd5,
        srl    = 5'd6,
        sra    = 5'd7,
        sllw   = 5'd8,
        srlw   = 5'd9,
        sraw   = 5'd10,
        op_xor = 5'd11,
        op_or  = 5'd12,
        op_and = 5'd13,
        slt    = 5'd14,   // signed
        sltu   = 5'd15
    } micop_t;

    ////////////////////////////////////////////////////////////////////////////
    // writeback record
    ////////////////////////////////////////////////////////////////////////////

    // leaves the lane and feeds the regfile write port and the late bypass
    typedef struct packed {
        rob_idx_t  rob_idx;
        logic      rd_wen;
        preg_idx_t rd_idx;
        xdata_t    result;
    } wb_info_t;

endpackage

// File: hw/int_exec_top.sv
`timescale 1ns/10ps

module int_exec_top import int_exec_pkg::*; (
    input  logic             clk,
    input  logic             rst,

    // issue
    input  logic             i_issue_vld,
    input  micop_t           i_micop,
    input  preg_idx_t        i_rs1_idx,
    input  preg_idx_t        i_rs2_idx,
    input  logic             i_use_imm,
    input  logic [IMM_W-1:0] i_imm,
    input  logic             i_rd_wen,
    input  preg_idx_t        i_rd_idx,
    input  rob_idx_t         i_rob_idx,
    output logic             o_issue_stall,

    // writeback
    input  logic             i_wb_stall,
    output logic             o_wb_vld,
    output rob_idx_t         o_wb_rob_idx,
    output logic             o_wb_rd_wen,
    output preg_idx_t        o_wb_rd_idx,
    output xdata_t           o_wb_result
);

    preg_idx_t rf_rs1_idx;
    preg_idx_t rf_rs2_idx;
    xdata_t    rf_rs1_data;
    xdata_t    rf_rs2_data;
    logic      rf_we;

    logic      willwrite_vld;
    preg_idx_t willwrite_idx;
    xdata_t    willwrite_data;
    logic      wb_vld;
    wb_info_t  wb_info;

    fu_issue_if issue_bus ();

    // commit to regfile only on an accepted record, never p0
    assign rf_we = wb_vld && !i_wb_stall && wb_info.rd_wen && (wb_info.rd_idx != '0);

    phys_regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .i_rs1_idx  (rf_rs1_idx),
        .i_rs2_idx  (rf_rs2_idx),
        .o_rs1_data (rf_rs1_data),
        .o_rs2_data (rf_rs2_data),
        .i_we       (rf_we),
        .i_wr_idx   (wb_info.rd_idx),
        .i_wr_data  (wb_info.result)
    );

    operand_read u_operand_read (
        .i_issue_vld      (i_issue_vld),
        .i_micop          (i_micop),
        .i_rs1_idx        (i_rs1_idx),
        .i_rs2_idx        (i_rs2_idx),
        .i_use_imm        (i_use_imm),
        .i_imm            (i_imm),
        .i_rd_wen         (i_rd_wen),
        .i_rd_idx         (i_rd_idx),
        .i_rob_idx        (i_rob_idx),
        .o_rs1_idx        (rf_rs1_idx),
        .o_rs2_idx        (rf_rs2_idx),
        .i_rs1_data       (rf_rs1_data),
        .i_rs2_data       (rf_rs2_data),
        .i_willwrite_vld  (willwrite_vld),
        .i_willwrite_idx  (willwrite_idx),
        .i_willwrite_data (willwrite_data),
        .i_wb_vld         (wb_vld),
        .i_wb_info        (wb_info),
        .out              (issue_bus.read_out)
    );

    alu u_alu (
        .clk              (clk),
        .rst              (rst),
        .i_wb_stall       (i_wb_stall),
        .in               (issue_bus.exec),
        .o_willwrite_vld  (willwrite_vld),
        .o_willwrite_idx  (willwrite_idx),
        .o_willwrite_data (willwrite_data),
        .o_wb_vld         (wb_vld),
        .o_wb_info        (wb_info)
    );

    assign o_issue_stall = i_wb_stall;   // whole lane freezes
    assign o_wb_vld      = wb_vld;
    assign o_wb_rob_idx  = wb_info.rob_idx;
    assign o_wb_rd_wen   = wb_info.rd_wen;
    assign o_wb_rd_idx   = wb_info.rd_idx;
    assign o_wb_result   = wb_info.result;

endmodule

// File: hw/operand_read.sv
`timescale 1ns/10ps

module operand_read import int_exec_pkg::*; (
    // issued micro-op
    input  logic             i_issue_vld,
    input  micop_t           i_micop,
    input  preg_idx_t        i_rs1_idx,
    input  preg_idx_t        i_rs2_idx,
    input  logic             i_use_imm,
    input  logic [IMM_W-1:0] i_imm,
    input  logic             i_rd_wen,
    input  preg_idx_t        i_rd_idx,
    input  rob_idx_t         i_rob_idx,

    // regfile read ports
    output preg_idx_t        o_rs1_idx,
    output preg_idx_t        o_rs2_idx,
    input  xdata_t           i_rs1_data,
    input  xdata_t           i_rs2_data,

    // early bypass from execute
    input  logic             i_willwrite_vld,
    input  preg_idx_t        i_willwrite_idx,
    input  xdata_t           i_willwrite_data,

    // late bypass from writeback
    input  logic             i_wb_vld,
    input  wb_info_t         i_wb_info,

    fu_issue_if.read_out     out
);

    xdata_t rs1_val;
    xdata_t rs2_val;
    xdata_t imm_sext;

    ////////////////////////////////////////////////////////////////////////////
    // bypass select
    ////////////////////////////////////////////////////////////////////////////

    // youngest producer first and regfile last
    function automatic xdata_t pick_src(input preg_idx_t idx, input xdata_t rf_data);
        if (idx == '0) begin
            return '0;
        end else if (i_willwrite_vld && (i_willwrite_idx == idx)) begin
            return i_willwrite_data;
        end else if (i_wb_vld && i_wb_info.rd_wen && (i_wb_info.rd_idx == idx)) begin
            return i_wb_info.result;
        end
        return rf_data;
    endfunction

    assign o_rs1_idx = i_rs1_idx;
    assign o_rs2_idx = i_rs2_idx;

    always_comb begin
        rs1_val = pick_src(i_rs1_idx, i_rs1_data);
        rs2_val = pick_src(i_rs2_idx, i_rs2_data);
    end

    assign imm_sext = {{(XLEN-IMM_W){i_imm[IMM_W-1]}}, i_imm};

    ////////////////////////////////////////////////////////////////////////////
    // drive the issue bus
    ////////////////////////////////////////////////////////////////////////////

    assign out.vld     = i_issue_vld;
    assign out.micop   = i_micop;
    assign out.src0    = rs1_val;
    assign out.src1    = i_use_imm ? imm_sext : rs2_val;
    assign out.imm     = (i_micop == lui) ? i_imm : '0;   // shifted in alu
    assign out.rd_wen  = i_issue_vld && i_rd_wen;
    assign out.rd_idx  = i_rd_idx;
    assign out.rob_idx = i_rob_idx;

endmodule

// File: hw/phys_regfile.sv
`timescale 1ns/10ps

module phys_regfile import int_exec_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // read ports
    input  preg_idx_t i_rs1_idx,
    input  preg_idx_t i_rs2_idx,
    output xdata_t    o_rs1_data,
    output xdata_t    o_rs2_data,

    // write port
    input  logic      i_we,
    input  preg_idx_t i_wr_idx,
    input  xdata_t    i_wr_data
);

    xdata_t regs [NUM_PREGS];

    ////////////////////////////////////////////////////////////////////////////
    // write
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read, write-first
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (i_we && (i_wr_idx == i_rs1_idx)) begin
            o_rs1_data = i_wr_data;
        end else begin
            o_rs1_data = regs[i_rs1_idx];
        end
    end

    always_comb begin
        if (i_we && (i_wr_idx == i_rs2_idx)) begin
            o_rs2_data = i_wr_data;
        end else begin
            o_rs2_data = regs[i_rs2_idx];
        end
    end

    // p0 is hardwired zero, writers must filter it out upstream
    a_no_p0_write: assert property (
        @(posedge clk) disable iff (rst) i_we |-> (i_wr_idx != '0)
    ) else $error("regfile write to physical register 0");

endmodule

// File: int_exec.f
hw/int_exec_pkg.sv
hw/fu_issue_if.sv
hw/phys_regfile.sv
hw/operand_read.sv
hw/alu.sv
hw/int_exec_top.sv
testbench/tb_int_exec.sv

// File: testbench/tb_int_exec.sv
`timescale 1ns/10ps

module tb_int_exec import int_exec_pkg::*; ();

    typedef struct {
        string            name;
        micop_t           micop;
        preg_idx_t        rs1;
        preg_idx_t        rs2;
        logic             use_imm;
        logic [IMM_W-1:0] imm;
        preg_idx_t        rd;
        logic             rd_wen;
        rob_idx_t         rob;
        int               stall;    // stall cycles while this op waits at issue
    } op_entry_t;

    typedef struct {
        string    name;
        wb_info_t info;
        int       issue_cyc;
        int       stalls_at_issue;
    } exp_rec_t;

    logic             clk;
    logic             rst;
    logic             i_issue_vld;
    micop_t           i_micop;
    preg_idx_t        i_rs1_idx;
    preg_idx_t        i_rs2_idx;
    logic             i_use_imm;
    logic [IMM_W-1:0] i_imm;
    logic             i_rd_wen;
    preg_idx_t        i_rd_idx;
    rob_idx_t         i_rob_idx;
    logic             i_wb_stall;
    logic             o_issue_stall;
    logic             o_wb_vld;
    rob_idx_t         o_wb_rob_idx;
    logic             o_wb_rd_wen;
    preg_idx_t        o_wb_rd_idx;
    xdata_t           o_wb_result;

    op_entry_t ops[$];
    exp_rec_t  exp_q[$];
    xdata_t    shadow [NUM_PREGS];
    string     cur_name;
    int        seed = 55;
    int        cycle = 0;
    int        cycle_limit;
    int        stall_total = 0;
    logic      held_vld = 1'b0;
    wb_info_t  held_info;

    int_exec_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .i_issue_vld   (i_issue_vld),
        .i_micop       (i_micop),
        .i_rs1_idx     (i_rs1_idx),
        .i_rs2_idx     (i_rs2_idx),
        .i_use_imm     (i_use_imm),
        .i_imm         (i_imm),
        .i_rd_wen      (i_rd_wen),
        .i_rd_idx      (i_rd_idx),
        .i_rob_idx     (i_rob_idx),
        .o_issue_stall (o_issue_stall),
        .i_wb_stall    (i_wb_stall),
        .o_wb_vld      (o_wb_vld),
        .o_wb_rob_idx  (o_wb_rob_idx),
        .o_wb_rd_wen   (o_wb_rd_wen),
        .o_wb_rd_idx   (o_wb_rd_idx),
        .o_wb_result   (o_wb_result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic xdata_t sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic xdata_t expect_value(input micop_t op, input xdata_t a,
                                            input xdata_t b, input logic [IMM_W-1:0] imm);
        case (op)
            lui:     return sext32({imm, 12'h000});
            add:     return a + b;
            sub:     return a + ~b + 64'd1;
            addw:    return sext32(a[31:0] + b[31:0]);
            subw:    return sext32(a[31:0] - b[31:0]);
            sll:     return a << b[5:0];
            srl:     return a >> b[5:0];
            sra:     return $signed(a) >>> b[5:0];
            sllw:    return sext32(a[31:0] << b[4:0]);
            srlw:    return sext32(a[31:0] >> b[4:0]);
            sraw:    return sext32($signed(a[31:0]) >>> b[4:0]);
            op_xor:  return a ^ b;
            op_or:   return a | b;
            op_and:  return a & b;
            slt:     return (a[63] != b[63]) ? {63'd0, a[63]} : {63'd0, a < b};  // sign decides first
            sltu:    return {63'd0, a < b};
            default: return '0;
        endcase
    endfunction

    function automatic int rand_field(input int n);
        return $random(seed) & ((1 << n) - 1);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_result(input string name, input xdata_t exp, input xdata_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_wb_info(input string name, input wb_info_t exp, input wb_info_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected record %h actual record %h",
                                name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("ERROR %s latency: expected %0d actual %0d", name, exp, act));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic push_op(input string name, input micop_t op, input int rs1, input int rs2,
                           input bit use_imm, input int imm, input int rd, input bit wen,
                           input int stall);
        op_entry_t e;
        e.name    = name;
        e.micop   = op;
        e.rs1     = preg_idx_t'(rs1);
        e.rs2     = preg_idx_t'(rs2);
        e.use_imm = use_imm;
        e.imm     = imm[IMM_W-1:0];
        e.rd      = preg_idx_t'(rd);
        e.rd_wen  = wen;
        e.rob     = rob_idx_t'(ops.size());
        e.stall   = stall;
        ops.push_back(e);
    endtask

    task automatic build_table();
        int     r;
        int     d;
        int     k;
        micop_t op;
        string  nm;
        for (r = 1; r < NUM_PREGS; r++) begin
            push_op($sformatf("reset read p%0d", r), add, r, 0, 0, 0, r, 1, 0);
        end
        // p1..p8 get random 64-bit values and p9 is scratch
        for (r = 1; r <= 8; r++) begin
            nm = $sformatf("seed p%0d", r);
            push_op(nm, lui, 0, 0, 0, rand_field(20), r, 1, 0);
            push_op(nm, sll, r, 0, 1, 32, r, 1, 0);
            push_op(nm, lui, 0, 0, 0, rand_field(20), 9, 1, 0);
            push_op(nm, op_xor, r, 9, 0, 0, r, 1, 0);
            push_op(nm, add, r, 0, 1, rand_field(20), r, 1, 0);
        end
        for (r = 0; r < 3 * NUM_MICOPS; r++) begin
            op = micop_t'(r % NUM_MICOPS);
            nm = $sformatf("%s #%0d", op.name(), r / NUM_MICOPS);
            push_op(nm, op, rand_field(5), rand_field(5), (r / NUM_MICOPS) == 1,
                    rand_field(20), 16 + rand_field(4), rand_field(3) != 0, 0);
        end
        push_op("negative value", add, 0, 0, 1, 'h80000, 10, 1, 0);
        push_op("positive value", add, 0, 0, 1, 5, 11, 1, 0);
        push_op("slt neg pos", slt, 10, 11, 0, 0, 12, 1, 0);
        push_op("sltu neg pos", sltu, 10, 11, 0, 0, 12, 1, 0);
        push_op("slt pos neg", slt, 11, 10, 0, 0, 12, 1, 0);
        push_op("sltu pos neg", sltu, 11, 10, 0, 0, 12, 1, 0);
        push_op("sra negative", sra, 10, 0, 1, 4, 13, 1, 0);
        push_op("srl negative", srl, 10, 0, 1, 4, 13, 1, 0);
        push_op("sraw negative", sraw, 10, 0, 1, 3, 13, 1, 0);
        // producer on p20 with its consumer d slots later
        for (k = 0; k < 2; k++) begin
            for (d = 1; d <= 3; d++) begin
                nm = $sformatf("dep distance %0d src%0d", d, k);
                push_op(nm, add, 20, 0, 1, rand_field(20), 20, 1, 0);
                for (r = 1; r < d; r++) begin
                    push_op(nm, op_or, 3, 4, 0, 0, 21, 1, 0);
                end
                if (k == 0) begin
                    push_op(nm, sub, 20, 5, 0, 0, 22, 1, 0);
                end else begin
                    push_op(nm, sub, 5, 20, 0, 0, 22, 1, 0);
                end
            end
        end
        push_op("write p0", add, 1, 0, 1, rand_field(20), 0, 1, 0);
        for (d = 1; d <= 3; d++) begin
            push_op($sformatf("read p0 distance %0d", d), add, 0, 7, 0, 0, 24, 1, 0);
        end
        push_op("stall issue", add, 26, 0, 1, rand_field(20), 26, 1, 3);
        push_op("stall dep 1", op_xor, 26, 1, 0, 0, 27, 1, 0);
        push_op("stall dep 2", sub, 27, 26, 0, 0, 28, 1, 5);
        push_op("stall dep 3", add, 28, 0, 1, rand_field(20), 26, 1, 1);
        push_op("stall shift", sllw, 26, 0, 1, 7, 29, 1, 2);
        push_op("after stall", op_and, 29, 28, 0, 0, 30, 1, 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // scoreboard, sampled on the rising edge
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        exp_rec_t rec;
        wb_info_t act;
        xdata_t   b;
        cycle++;
        if (cycle > cycle_limit) begin
            abort_run($sformatf("timeout: no finish after %0d cycles", cycle_limit));
        end
        if (!rst) begin
            act.rob_idx = o_wb_rob_idx;
            act.rd_wen  = o_wb_rd_wen;
            act.rd_idx  = o_wb_rd_idx;
            act.result  = o_wb_result;
            check_flag("issue stall follows wb stall", i_wb_stall, o_issue_stall);
            if (held_vld) begin
                check_flag("wb valid held under stall", 1'b1, o_wb_vld);
                check_wb_info("wb record held under stall", held_info, act);
            end
            held_vld  = o_wb_vld && i_wb_stall;
            held_info = act;
            if (o_wb_vld && !i_wb_stall) begin
                if (exp_q.size() == 0) begin
                    abort_run("writeback record arrived while none was outstanding");
                end
                rec = exp_q.pop_front();
                check_result(rec.name, rec.info.result, o_wb_result);
                check_wb_info(rec.name, rec.info, act);
                check_latency(rec.name, 2 + stall_total - rec.stalls_at_issue,
                              cycle - rec.issue_cyc);
            end
            if (i_issue_vld && !i_wb_stall) begin
                b = i_use_imm ? xdata_t'($signed(i_imm)) : shadow[i_rs2_idx];
                rec.name            = cur_name;
                rec.info.rob_idx    = i_rob_idx;
                rec.info.rd_wen     = i_rd_wen;
                rec.info.rd_idx     = i_rd_idx;
                rec.info.result     = expect_value(i_micop, shadow[i_rs1_idx], b, i_imm);
                rec.issue_cyc       = cycle;
                rec.stalls_at_issue = stall_total;
                exp_q.push_back(rec);
                if (i_rd_wen && (i_rd_idx != '0)) begin
                    shadow[i_rd_idx] = rec.info.result;   // p0 stays zero
                end
            end
            if (i_wb_stall) begin
                stall_total++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // driver, falling edge
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int total_stall;
        int n;
        rst         = 1'b1;
        i_issue_vld = 1'b0;
        i_micop     = add;
        i_rs1_idx   = '0;
        i_rs2_idx   = '0;
        i_use_imm   = 1'b0;
        i_imm       = '0;
        i_rd_wen    = 1'b0;
        i_rd_idx    = '0;
        i_rob_idx   = '0;
        i_wb_stall  = 1'b0;
        cur_name    = "idle";
        for (n = 0; n < NUM_PREGS; n++) begin
            shadow[n] = '0;
        end
        build_table();
        total_stall = 0;
        foreach (ops[i]) begin
            total_stall += ops[i].stall;
        end
        cycle_limit = ops.size() * 4 + total_stall + 50;

        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_flag("wb valid after reset", 1'b0, o_wb_vld);

        foreach (ops[i]) begin
            @(negedge clk);
            cur_name    = ops[i].name;
            i_issue_vld = 1'b1;
            i_micop     = ops[i].micop;
            i_rs1_idx   = ops[i].rs1;
            i_rs2_idx   = ops[i].rs2;
            i_use_imm   = ops[i].use_imm;
            i_imm       = ops[i].imm;
            i_rd_wen    = ops[i].rd_wen;
            i_rd_idx    = ops[i].rd;
            i_rob_idx   = ops[i].rob;
            i_wb_stall  = (ops[i].stall != 0);
            repeat (ops[i].stall) @(negedge clk);   // op held at issue meanwhile
            i_wb_stall  = 1'b0;
        end
        @(negedge clk);
        i_issue_vld = 1'b0;
        i_rd_wen    = 1'b0;

        for (n = 0; (n < 10) && (exp_q.size() != 0); n++) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);   // catch stray records
        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d expected writeback records never arrived", exp_q.size()));
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule
